// File: logic/ctrlPkg.sv
package ctrlPkg;

    // opcode and funct fields of the instruction word
    localparam int OpcodeWidth = 6;

    // step counter inside one phase
    localparam int StepWidth = 3;

    // everything except R-type is unsupported
    typedef enum logic [OpcodeWidth-1:0] {
        RType = 6'd0
    } opcodeT;

    typedef enum logic [OpcodeWidth-1:0] {
        FnSll   = 6'd0,
        FnJr    = 6'd8,
        FnBreak = 6'd13,
        FnRte   = 6'd19,
        FnAdd   = 6'd32,
        FnSub   = 6'd34,
        FnAnd   = 6'd36,
        FnSlt   = 6'd42
    } functT;

    typedef enum logic [3:0] {
        OpAdd,
        OpSub,
        OpAnd,
        OpSlt,
        OpJr,
        OpBreak,
        OpRte,
        OpSll,
        OpUnsupported
    } instrOpT;

    typedef enum logic [1:0] {
        PhReset,
        PhFetch,
        PhDecode,
        PhExecute
    } phaseT;

    typedef enum logic [2:0] {
        AluHold = 3'd0,
        AluAdd  = 3'd1,
        AluSub  = 3'd2,
        AluAnd  = 3'd3,
        AluSlt  = 3'd7
    } aluOpT;

    typedef enum logic [2:0] {
        PcIncrement = 3'd0,
        PcFromRegA  = 3'd5
    } pcSourceT;

    typedef enum logic [2:0] {
        ShiftIdle = 3'd0,
        ShiftLoad = 3'd1,
        ShiftLeft = 3'd2
    } shiftOpT;

    // register file write-data mux select
    typedef enum logic [3:0] {
        WdNone      = 4'd0,
        WdAluOut    = 4'd5,
        WdShifter   = 4'd7,
        WdSltResult = 4'd9
    } writeDataT;

endpackage

// File: logic/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder import ctrlPkg::*; (
    input  logic [OpcodeWidth-1:0] opcode,
    input  logic [OpcodeWidth-1:0] funct,
    output instrOpT                decodedOp
);

    logic isRType;

    assign isRType = (opcodeT'(opcode) == RType);

    // only R-type carries a supported operation, picked by funct
    always_comb begin
        decodedOp = OpUnsupported;
        if (isRType) begin
            case (functT'(funct))
                FnAdd: begin
                    decodedOp = OpAdd;
                end
                FnSub: begin
                    decodedOp = OpSub;
                end
                FnAnd: begin
                    decodedOp = OpAnd;
                end
                FnSlt: begin
                    decodedOp = OpSlt;
                end
                FnJr: begin
                    decodedOp = OpJr;
                end
                FnBreak: begin
                    decodedOp = OpBreak;
                end
                FnRte: begin
                    decodedOp = OpRte;
                end
                FnSll: begin
                    decodedOp = OpSll;
                end
                default: begin
                    decodedOp = OpUnsupported;
                end
            endcase
        end
    end

endmodule

// File: logic/cycleSequencer.sv
`timescale 1ns/100ps

module cycleSequencer import ctrlPkg::*; #(
    parameter int MemWaitCycles = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  instrOpT              decodedOp,
    output phaseT                phase,
    output logic [StepWidth-1:0] step,
    output instrOpT              activeOp
);

    // fetch has MemWaitCycles read steps plus the PC/IR write step
    localparam logic [StepWidth-1:0] FetchLast = StepWidth'(MemWaitCycles);
    localparam logic [StepWidth-1:0] DecodeLast = StepWidth'(2);

    logic [StepWidth-1:0] lastStep;
    logic                 stepDone;

    // last step index of each execute sequence
    function automatic logic [StepWidth-1:0] execLast(instrOpT op);
        case (op)
            OpAdd, OpSub, OpAnd, OpSlt, OpJr, OpBreak: begin
                return StepWidth'(1);
            end
            OpSll: begin
                return StepWidth'(2);
            end
            default: begin
                return StepWidth'(0);
            end
        endcase
    endfunction

    always_comb begin
        case (phase)
            PhFetch: begin
                lastStep = FetchLast;
            end
            PhDecode: begin
                lastStep = DecodeLast;
            end
            PhExecute: begin
                lastStep = execLast(activeOp);
            end
            default: begin
                lastStep = '0;
            end
        endcase
    end

    assign stepDone = (step == lastStep);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= PhReset;
            step     <= '0;
            activeOp <= OpUnsupported;
        end else if (stepDone) begin
            step <= '0;
            case (phase)
                PhReset: begin
                    phase <= PhFetch;
                end
                PhFetch: begin
                    phase <= PhDecode;
                end
                PhDecode: begin
                    // dispatch; unsupported codes skip execute
                    activeOp <= decodedOp;
                    if (decodedOp == OpUnsupported) begin
                        phase <= PhFetch;
                    end else begin
                        phase <= PhExecute;
                    end
                end
                default: begin
                    phase <= PhFetch;
                end
            endcase
        end else begin
            step <= step + 1'b1;
        end
    end

    stepInRange: assert property (@(posedge clk) disable iff (reset)
        step <= lastStep)
        else $error("step %0d beyond last step %0d", step, lastStep);

endmodule

// File: logic/signalEncoder.sv
`timescale 1ns/100ps

module signalEncoder import ctrlPkg::*; #(
    parameter int MemWaitCycles = 3
) (
    input  phaseT                phase,
    input  logic [StepWidth-1:0] step,
    input  instrOpT              activeOp,
    output logic                 pcWrite,
    output logic                 memRead,
    output logic                 irWrite,
    output logic                 regWrite,
    output logic                 aluOutWrite,
    output logic                 resetHold,
    output logic [1:0]           aluSrcA,
    output logic [1:0]           aluSrcB,
    output aluOpT                aluControl,
    output pcSourceT             pcSource,
    output shiftOpT              shiftControl,
    output writeDataT            writeData
);

    localparam logic [StepWidth-1:0] FetchLast = StepWidth'(MemWaitCycles);

    // ALU code for the R-type arithmetic group
    function automatic aluOpT aluFor(instrOpT op);
        case (op)
            OpSub: begin
                return AluSub;
            end
            OpAnd: begin
                return AluAnd;
            end
            OpSlt: begin
                return AluSlt;
            end
            default: begin
                return AluAdd;
            end
        endcase
    endfunction

    always_comb begin
        pcWrite      = 1'b0;
        memRead      = 1'b0;
        irWrite      = 1'b0;
        regWrite     = 1'b0;
        aluOutWrite  = 1'b0;
        resetHold    = 1'b0;
        aluSrcA      = 2'd0;
        aluSrcB      = 2'd0;
        aluControl   = AluHold;
        pcSource     = PcIncrement;
        shiftControl = ShiftIdle;
        writeData    = WdNone;

        case (phase)
            PhReset: begin
                resetHold = 1'b1;
            end
            PhFetch: begin
                if (step < FetchLast) begin
                    // read memory while the ALU forms PC+4
                    memRead    = 1'b1;
                    aluSrcB    = 2'd1;
                    aluControl = AluAdd;
                end else begin
                    pcWrite = 1'b1;
                    irWrite = 1'b1;
                end
            end
            PhDecode: begin
                if (step == StepWidth'(0)) begin
                    aluSrcB    = 2'd1;
                    aluControl = AluAdd;
                end else if (step == StepWidth'(1)) begin
                    aluOutWrite = 1'b1;
                end
            end
            PhExecute: begin
                case (activeOp)
                    OpAdd, OpSub, OpAnd, OpSlt: begin
                        if (step == StepWidth'(0)) begin
                            aluSrcA    = 2'd2;
                            aluControl = aluFor(activeOp);
                        end else begin
                            regWrite  = 1'b1;
                            writeData = (activeOp == OpSlt) ? WdSltResult : WdAluOut;
                        end
                    end
                    OpJr: begin
                        if (step == StepWidth'(0)) begin
                            aluSrcA = 2'd2;
                        end else begin
                            pcWrite  = 1'b1;
                            pcSource = PcFromRegA;
                        end
                    end
                    OpBreak: begin
                        // PC-4 first, then write it back
                        if (step == StepWidth'(0)) begin
                            aluSrcB    = 2'd1;
                            aluControl = AluSub;
                        end else begin
                            pcWrite = 1'b1;
                        end
                    end
                    OpRte: begin
                        pcWrite  = 1'b1;
                        pcSource = PcFromRegA;
                    end
                    OpSll: begin
                        if (step == StepWidth'(0)) begin
                            shiftControl = ShiftLoad;
                        end else if (step == StepWidth'(1)) begin
                            shiftControl = ShiftLeft;
                        end else begin
                            regWrite  = 1'b1;
                            writeData = WdShifter;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase

        assert (!(pcWrite && regWrite))
            else $error("pcWrite and regWrite both high");
        assert (!aluOutWrite || phase == PhDecode)
            else $error("aluOutWrite outside decode");
    end

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/100ps

module controlUnit import ctrlPkg::*; #(
    parameter int MemWaitCycles = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [OpcodeWidth-1:0] opcode,
    input  logic [OpcodeWidth-1:0] funct,
    output logic                   pcWrite,
    output logic                   memRead,
    output logic                   irWrite,
    output logic                   regWrite,
    output logic                   aluOutWrite,
    output logic                   resetHold,
    output logic [1:0]             aluSrcA,
    output logic [1:0]             aluSrcB,
    output aluOpT                  aluControl,
    output pcSourceT               pcSource,
    output shiftOpT                shiftControl,
    output writeDataT              writeData
);

    instrOpT              decodedOp;
    instrOpT              activeOp;
    phaseT                phase;
    logic [StepWidth-1:0] step;

    instrDecoder i_decoder (
        .opcode    (opcode),
        .funct     (funct),
        .decodedOp (decodedOp)
    );

    cycleSequencer #(
        .MemWaitCycles (MemWaitCycles)
    ) i_sequencer (
        .clk       (clk),
        .reset     (reset),
        .decodedOp (decodedOp),
        .phase     (phase),
        .step      (step),
        .activeOp  (activeOp)
    );

    signalEncoder #(
        .MemWaitCycles (MemWaitCycles)
    ) i_encoder (
        .phase        (phase),
        .step         (step),
        .activeOp     (activeOp),
        .pcWrite      (pcWrite),
        .memRead      (memRead),
        .irWrite      (irWrite),
        .regWrite     (regWrite),
        .aluOutWrite  (aluOutWrite),
        .resetHold    (resetHold),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .aluControl   (aluControl),
        .pcSource     (pcSource),
        .shiftControl (shiftControl),
        .writeData    (writeData)
    );

endmodule

// File: verif/ctrlModel.svh
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

// one cycle of expected control outputs
typedef struct packed {
    logic       pcWrite;
    logic       memRead;
    logic       irWrite;
    logic       regWrite;
    logic       aluOutWrite;
    logic       resetHold;
    logic [1:0] aluSrcA;
    logic [1:0] aluSrcB;
    logic [2:0] aluControl;
    logic [2:0] pcSource;
    logic [2:0] shiftControl;
    logic [3:0] writeData;
} ctrlVecT;

// R-type funct codes of the instruction set
function automatic instrOpT decodeRef(logic [5:0] op, logic [5:0] fn);
    if (op != 6'd0) begin
        return OpUnsupported;
    end
    case (fn)
        6'd32: return OpAdd;
        6'd34: return OpSub;
        6'd36: return OpAnd;
        6'd42: return OpSlt;
        6'd8: return OpJr;
        6'd13: return OpBreak;
        6'd19: return OpRte;
        6'd0: return OpSll;
        default: return OpUnsupported;
    endcase
endfunction

function automatic int execCycles(instrOpT op);
    case (op)
        OpAdd, OpSub, OpAnd, OpSlt, OpJr, OpBreak: return 2;
        OpRte: return 1;
        OpSll: return 3;
        default: return 0;
    endcase
endfunction

// cycles spent in a phase before moving on
function automatic int phaseCycles(phaseT ph, instrOpT op, int memWait);
    case (ph)
        PhFetch: return memWait + 1;
        PhDecode: return 3;
        PhExecute: return execCycles(op);
        default: return 1;
    endcase
endfunction

function automatic ctrlVecT expectedCtrl(phaseT ph, int stepIdx, instrOpT op, int memWait);
    ctrlVecT v;
    v = '0;
    case (ph)
        PhReset: begin
            v.resetHold = 1'b1;
        end
        PhFetch: begin
            if (stepIdx < memWait) begin
                v.memRead = 1'b1;
                v.aluSrcB = 2'd1;
                v.aluControl = AluAdd;
            end else begin
                v.pcWrite = 1'b1;
                v.irWrite = 1'b1;
            end
        end
        PhDecode: begin
            if (stepIdx == 0) begin
                v.aluSrcB = 2'd1;
                v.aluControl = AluAdd;
            end else if (stepIdx == 1) begin
                v.aluOutWrite = 1'b1;
            end
        end
        default: begin
            case (op)
                OpAdd, OpSub, OpAnd, OpSlt: begin
                    if (stepIdx == 0) begin
                        v.aluSrcA = 2'd2;
                        v.aluControl = (op == OpAdd) ? AluAdd :
                                       (op == OpSub) ? AluSub :
                                       (op == OpAnd) ? AluAnd : AluSlt;
                    end else begin
                        v.regWrite = 1'b1;
                        v.writeData = (op == OpSlt) ? WdSltResult : WdAluOut;
                    end
                end
                OpJr: begin
                    if (stepIdx == 0) begin
                        v.aluSrcA = 2'd2;
                    end else begin
                        v.pcWrite = 1'b1;
                        v.pcSource = PcFromRegA;
                    end
                end
                OpBreak: begin
                    if (stepIdx == 0) begin
                        v.aluSrcB = 2'd1;
                        v.aluControl = AluSub;
                    end else begin
                        v.pcWrite = 1'b1;
                        v.pcSource = PcIncrement;
                    end
                end
                OpRte: begin
                    v.pcWrite = 1'b1;
                    v.pcSource = PcFromRegA;
                end
                OpSll: begin
                    if (stepIdx == 0) begin
                        v.shiftControl = ShiftLoad;
                    end else if (stepIdx == 1) begin
                        v.shiftControl = ShiftLeft;
                    end else begin
                        v.regWrite = 1'b1;
                        v.writeData = WdShifter;
                    end
                end
                default: begin
                end
            endcase
        end
    endcase
    return v;
endfunction

`endif

// File: verif/controlUnitTb.sv
`timescale 1ns/100ps

module controlUnitTb import ctrlPkg::*; ();

    localparam int MemWaitCycles = 3;
    localparam int RandomCount = 200;
    // 200 instructions of at most 12 cycles plus the directed tests
    localparam int CycleLimit = 3000;
    localparam logic [5:0] KeptFuncts [8] = '{6'd32, 6'd34, 6'd36, 6'd42,
                                             6'd8, 6'd13, 6'd19, 6'd0};

    logic                   clk;
    logic                   reset;
    logic [OpcodeWidth-1:0] opcode;
    logic [OpcodeWidth-1:0] funct;
    logic                   pcWrite;
    logic                   memRead;
    logic                   irWrite;
    logic                   regWrite;
    logic                   aluOutWrite;
    logic                   resetHold;
    logic [1:0]             aluSrcA;
    logic [1:0]             aluSrcB;
    aluOpT                  aluControl;
    pcSourceT               pcSource;
    shiftOpT                shiftControl;
    writeDataT              writeData;

    // model copy of the DUT state after each edge
    phaseT   refPhase;
    int      refStep;
    instrOpT refOp;

    int errors;
    int checks;
    int cycles;
    int testsPassed;
    int testsFailed;

    `include "ctrlModel.svh"

    controlUnit #(
        .MemWaitCycles (MemWaitCycles)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .funct        (funct),
        .pcWrite      (pcWrite),
        .memRead      (memRead),
        .irWrite      (irWrite),
        .regWrite     (regWrite),
        .aluOutWrite  (aluOutWrite),
        .resetHold    (resetHold),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .aluControl   (aluControl),
        .pcSource     (pcSource),
        .shiftControl (shiftControl),
        .writeData    (writeData)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("run stopped after %0d cycles without finishing the tests", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic compareField(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s expected 0x%0h got 0x%0h at cycle %0d",
                     name, expected, actual, cycles);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin : compareModel
        ctrlVecT want;
        want = expectedCtrl(refPhase, refStep, refOp, MemWaitCycles);
        compareField("pcWrite", 8'(want.pcWrite), 8'(pcWrite));
        compareField("memRead", 8'(want.memRead), 8'(memRead));
        compareField("irWrite", 8'(want.irWrite), 8'(irWrite));
        compareField("regWrite", 8'(want.regWrite), 8'(regWrite));
        compareField("aluOutWrite", 8'(want.aluOutWrite), 8'(aluOutWrite));
        compareField("resetHold", 8'(want.resetHold), 8'(resetHold));
        compareField("aluSrcA", 8'(want.aluSrcA), 8'(aluSrcA));
        compareField("aluSrcB", 8'(want.aluSrcB), 8'(aluSrcB));
        compareField("aluControl", 8'(want.aluControl), 8'(aluControl));
        compareField("pcSource", 8'(want.pcSource), 8'(pcSource));
        compareField("shiftControl", 8'(want.shiftControl), 8'(shiftControl));
        compareField("writeData", 8'(want.writeData), 8'(writeData));

        // state after the coming rising edge
        if (reset) begin
            refPhase = PhReset;
            refStep = 0;
            refOp = OpUnsupported;
        end else if (refStep == phaseCycles(refPhase, refOp, MemWaitCycles) - 1) begin
            refStep = 0;
            case (refPhase)
                PhReset: refPhase = PhFetch;
                PhFetch: refPhase = PhDecode;
                PhDecode: begin
                    refOp = decodeRef(opcode, funct);
                    refPhase = (execCycles(refOp) == 0) ? PhFetch : PhExecute;
                end
                default: refPhase = PhFetch;
            endcase
        end else begin
            refStep++;
        end
    end

    task automatic waitFetchEnd(output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (irWrite !== 1'b1);
    endtask

    // runs from one falling edge with irWrite high to the next
    task automatic issueInstr(input logic [5:0] op, input logic [5:0] fn, input string label);
        int n;
        int expected;
        expected = 3 + execCycles(decodeRef(op, fn)) + MemWaitCycles + 1;
        @(posedge clk);
        opcode <= op;
        funct <= fn;
        waitFetchEnd(n);
        if (n != expected) begin
            errors++;
            $display("%s took %0d cycles from fetch to fetch instead of %0d",
                     label, n, expected);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errors == errorsBefore) begin
            testsPassed++;
            $display("test %s: passed", name);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, errors - errorsBefore);
        end
    endtask

    initial begin
        int n;
        int errorsBefore;
        int pick;
        int holdCycles;
        logic [5:0] op;
        logic [5:0] fn;
        void'($urandom(300));
        clk = 1'b0;
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        refPhase = PhReset;
        refStep = 0;
        refOp = OpUnsupported;
        errors = 0;
        checks = 0;
        cycles = 0;
        testsPassed = 0;
        testsFailed = 0;

        errorsBefore = errors;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        waitFetchEnd(n);
        // one reset-hold cycle, then the whole fetch
        if (n != MemWaitCycles + 2) begin
            errors++;
            $display("first fetch ended after %0d cycles instead of %0d", n, MemWaitCycles + 2);
        end
        reportTest("reset", errorsBefore);

        errorsBefore = errors;
        issueInstr(6'd0, 6'd32, "ADD");
        issueInstr(6'd0, 6'd34, "SUB");
        issueInstr(6'd0, 6'd36, "AND");
        issueInstr(6'd0, 6'd42, "SLT");
        reportTest("alu ops", errorsBefore);

        errorsBefore = errors;
        issueInstr(6'd0, 6'd8, "JR");
        issueInstr(6'd0, 6'd19, "RTE");
        issueInstr(6'd0, 6'd13, "BREAK");
        reportTest("pc redirects", errorsBefore);

        errorsBefore = errors;
        issueInstr(6'd0, 6'd0, "SLL");
        reportTest("sll", errorsBefore);

        errorsBefore = errors;
        issueInstr(6'h23, 6'd32, "load opcode");
        issueInstr(6'h04, 6'd0, "branch opcode");
        issueInstr(6'd0, 6'h3f, "unlisted funct");
        reportTest("unsupported", errorsBefore);

        errorsBefore = errors;
        for (int i = 0; i < RandomCount; i++) begin
            pick = $urandom_range(9, 0);
            if (pick < 8) begin
                op = 6'd0;
                fn = KeptFuncts[pick];
            end else if (pick == 8) begin
                op = 6'($urandom_range(63, 1));
                fn = 6'($urandom);
            end else begin
                op = 6'd0;
                do begin
                    fn = 6'($urandom);
                end while (decodeRef(6'd0, fn) != OpUnsupported);
            end
            if (i == RandomCount / 2) begin
                // reset lands somewhere inside this instruction
                holdCycles = $urandom_range(6, 1);
                @(posedge clk);
                opcode <= op;
                funct <= fn;
                repeat (holdCycles) @(posedge clk);
                reset <= 1'b1;
                repeat (2) @(posedge clk);
                reset <= 1'b0;
                waitFetchEnd(n);
            end else begin
                issueInstr(op, fn, "random instruction");
            end
        end
        reportTest("random stream", errorsBefore);

        $display("tests passed %0d failed %0d, %0d checks, %0d errors",
                 testsPassed, testsFailed, checks, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: controlUnit.f
+incdir+verif
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/cycleSequencer.sv
logic/signalEncoder.sv
logic/controlUnit.sv
verif/controlUnitTb.sv

// File: run.sh
#!/usr/bin/env bash
# build the control unit testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module controlUnitTb -f controlUnit.f; then
    echo "verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/VcontrolUnitTb)
simStatus=$?
echo "$simOutput"
if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Result: PASSED" <<< "$simOutput"; then
    exit 0
fi
echo "pass message not found"
exit 1
